/* verilog/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    localparam int xlen = 32;

    // ****************************************
    // instruction classes and alu operations
    // ****************************************

    typedef enum logic [3:0] {
        op_alu_reg,
        op_alu_imm,
        op_lui,
        op_auipc,
        op_jal,
        op_jalr,
        op_branch,
        op_load,
        op_store,
        op_ebreak,
        op_illegal
    } opcode_e;

    typedef enum logic [1:0] {
        alu_add,
        alu_sub,
        alu_pass_b
    } alu_op_e;

    // ****************************************
    // records passed between blocks
    // ****************************************

    typedef struct packed {
        opcode_e         opcode;
        alu_op_e         alu_op;
        logic [3:0]      rs1;
        logic [3:0]      rs2;
        logic [3:0]      rd;
        logic [xlen-1:0] imm;
        logic            src1_is_pc;
        logic            src2_is_imm;
        logic            gpr_we;
        logic            load;
        logic            store;
        logic            byte_access;
        logic            branch_ne;
    } ctrl_t;

    // one retired instruction
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] inst;
        logic [3:0]      rd;
        logic [xlen-1:0] wdata;
        logic            gpr_we;
    } commit_t;

    typedef struct packed {
        logic [xlen-1:0] addr;
        logic [xlen-1:0] data;
        logic            byte_access;
    } store_t;

endpackage

`default_nettype wire

/* verilog/rv_idu.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_idu (
    input  wire  [rv_pkg::xlen-1:0] inst,
    output rv_pkg::ctrl_t           ctrl
);

    logic [6:0]              opcode;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    logic [rv_pkg::xlen-1:0] imm_i;
    logic [rv_pkg::xlen-1:0] imm_s;
    logic [rv_pkg::xlen-1:0] imm_b;
    logic [rv_pkg::xlen-1:0] imm_u;
    logic [rv_pkg::xlen-1:0] imm_j;
    logic                    use_rd;
    logic                    use_rs1;
    logic                    use_rs2;
    logic                    bad_index;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        ctrl        = '0;
        ctrl.opcode = rv_pkg::op_illegal;
        ctrl.alu_op = rv_pkg::alu_add;
        ctrl.rs1    = inst[18:15];
        ctrl.rs2    = inst[23:20];
        ctrl.rd     = inst[10:7];
        use_rd      = 1'b0;
        use_rs1     = 1'b0;
        use_rs2     = 1'b0;

        case (opcode)
            7'b0110011: begin
                if (funct3 == 3'b000 && (funct7 == 7'b0000000 || funct7 == 7'b0100000)) begin
                    ctrl.opcode = rv_pkg::op_alu_reg;
                    ctrl.alu_op = funct7[5] ? rv_pkg::alu_sub : rv_pkg::alu_add;
                    ctrl.gpr_we = 1'b1;
                    use_rd      = 1'b1;
                    use_rs1     = 1'b1;
                    use_rs2     = 1'b1;
                end
            end
            7'b0010011: begin
                if (funct3 == 3'b000) begin
                    ctrl.opcode      = rv_pkg::op_alu_imm;
                    ctrl.imm         = imm_i;
                    ctrl.src2_is_imm = 1'b1;
                    ctrl.gpr_we      = 1'b1;
                    use_rd           = 1'b1;
                    use_rs1          = 1'b1;
                end
            end
            7'b0110111: begin
                ctrl.opcode      = rv_pkg::op_lui;
                ctrl.alu_op      = rv_pkg::alu_pass_b;
                ctrl.imm         = imm_u;
                ctrl.src2_is_imm = 1'b1;
                ctrl.gpr_we      = 1'b1;
                use_rd           = 1'b1;
            end
            7'b0010111: begin
                ctrl.opcode      = rv_pkg::op_auipc;
                ctrl.imm         = imm_u;
                ctrl.src1_is_pc  = 1'b1;
                ctrl.src2_is_imm = 1'b1;
                ctrl.gpr_we      = 1'b1;
                use_rd           = 1'b1;
            end
            7'b1101111: begin
                ctrl.opcode = rv_pkg::op_jal;
                ctrl.imm    = imm_j;
                ctrl.gpr_we = 1'b1;
                use_rd      = 1'b1;
            end
            7'b1100111: begin
                if (funct3 == 3'b000) begin
                    ctrl.opcode = rv_pkg::op_jalr;
                    ctrl.imm    = imm_i;
                    ctrl.gpr_we = 1'b1;
                    use_rd      = 1'b1;
                    use_rs1     = 1'b1;
                end
            end
            7'b1100011: begin
                // beq or bne
                if (funct3[2:1] == 2'b00) begin
                    ctrl.opcode    = rv_pkg::op_branch;
                    ctrl.imm       = imm_b;
                    ctrl.branch_ne = funct3[0];
                    use_rs1        = 1'b1;
                    use_rs2        = 1'b1;
                end
            end
            7'b0000011: begin
                // lw or lbu
                if (funct3 == 3'b010 || funct3 == 3'b100) begin
                    ctrl.opcode      = rv_pkg::op_load;
                    ctrl.imm         = imm_i;
                    ctrl.src2_is_imm = 1'b1;
                    ctrl.load        = 1'b1;
                    ctrl.byte_access = funct3[2];
                    ctrl.gpr_we      = 1'b1;
                    use_rd           = 1'b1;
                    use_rs1          = 1'b1;
                end
            end
            7'b0100011: begin
                // sw or sb
                if (funct3 == 3'b010 || funct3 == 3'b000) begin
                    ctrl.opcode      = rv_pkg::op_store;
                    ctrl.imm         = imm_s;
                    ctrl.src2_is_imm = 1'b1;
                    ctrl.store       = 1'b1;
                    ctrl.byte_access = ~funct3[1];
                    use_rs1          = 1'b1;
                    use_rs2          = 1'b1;
                end
            end
            7'b1110011: begin
                if (inst == 32'h0010_0073) begin
                    ctrl.opcode = rv_pkg::op_ebreak;
                end
            end
            default: ;
        endcase

        // only the fields an instruction really uses count for the rv32e index check
        bad_index = (use_rd & inst[11]) | (use_rs1 & inst[19]) | (use_rs2 & inst[24]);

        if (ctrl.opcode == rv_pkg::op_illegal || bad_index) begin
            ctrl.opcode = rv_pkg::op_illegal;
            ctrl.gpr_we = 1'b0;
            ctrl.load   = 1'b0;
            ctrl.store  = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* verilog/rv_gpr.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_gpr (
    input  wire                     clock,
    input  wire                     reset,
    input  wire  [3:0]              rs1,
    input  wire  [3:0]              rs2,
    output logic [rv_pkg::xlen-1:0] src1,
    output logic [rv_pkg::xlen-1:0] src2,
    input  wire  [3:0]              gpr_waddr,
    input  wire  [rv_pkg::xlen-1:0] gpr_wdata,
    input  wire                     gpr_wen
);

    logic [rv_pkg::xlen-1:0] regs [16];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (gpr_wen && gpr_waddr != 4'd0) begin
            regs[gpr_waddr] <= gpr_wdata;
        end
    end

    // x0 reads zero
    assign src1 = (rs1 == 4'd0) ? '0 : regs[rs1];
    assign src2 = (rs2 == 4'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* verilog/rv_exu.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_exu (
    input  wire  rv_pkg::ctrl_t     ctrl,
    input  wire  [rv_pkg::xlen-1:0] src1,
    input  wire  [rv_pkg::xlen-1:0] src2,
    input  wire  [rv_pkg::xlen-1:0] pc,
    output logic [rv_pkg::xlen-1:0] result,
    output logic [rv_pkg::xlen-1:0] dnpc
);

    logic [rv_pkg::xlen-1:0] op_a;
    logic [rv_pkg::xlen-1:0] op_b;
    logic [rv_pkg::xlen-1:0] alu_out;
    logic [rv_pkg::xlen-1:0] snpc;
    logic [rv_pkg::xlen-1:0] target;
    logic                    taken;

    assign op_a = ctrl.src1_is_pc ? pc : src1;
    assign op_b = ctrl.src2_is_imm ? ctrl.imm : src2;

    always_comb begin
        case (ctrl.alu_op)
            rv_pkg::alu_add:    alu_out = op_a + op_b;
            rv_pkg::alu_sub:    alu_out = op_a - op_b;
            rv_pkg::alu_pass_b: alu_out = op_b;
            default:            alu_out = op_a + op_b;
        endcase
    end

    // ****************************************
    // next pc
    // ****************************************

    assign snpc   = pc + 32'd4;
    assign target = pc + ctrl.imm;
    assign taken  = (src1 == src2) ^ ctrl.branch_ne;

    always_comb begin
        case (ctrl.opcode)
            rv_pkg::op_jal:    dnpc = target;
            rv_pkg::op_jalr:   dnpc = (src1 + ctrl.imm) & ~32'd1;
            rv_pkg::op_branch: dnpc = taken ? target : snpc;
            default:           dnpc = snpc;
        endcase
    end

    // jumps write the link address
    assign result = (ctrl.opcode == rv_pkg::op_jal || ctrl.opcode == rv_pkg::op_jalr)
                  ? snpc : alu_out;

endmodule

`default_nettype wire

/* verilog/rv_lsu.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_lsu #(
    parameter int dmem_words = 64
) (
    input  wire                     clock,
    input  wire                     reset,
    input  wire  rv_pkg::ctrl_t     ctrl,
    input  wire  [rv_pkg::xlen-1:0] addr,
    input  wire  [rv_pkg::xlen-1:0] wdata,
    output logic [rv_pkg::xlen-1:0] rdata
);

    localparam int aw = (dmem_words > 1) ? $clog2(dmem_words) : 1;

    logic [rv_pkg::xlen-1:0] mem [dmem_words];
    logic [rv_pkg::xlen-1:0] word_addr;
    logic [aw-1:0]           idx;

    // wraps on the depth in words
    assign word_addr = (addr >> 2) % dmem_words;
    assign idx       = word_addr[aw-1:0];

    assign rdata = mem[idx];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < dmem_words; i++) begin
                mem[i] <= '0;
            end
        end else if (ctrl.store) begin
            if (ctrl.byte_access) begin
                // byte lane from the low address bits
                mem[idx][{addr[1:0], 3'b000} +: 8] <= wdata[7:0];
            end else begin
                mem[idx] <= wdata;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/rv_wbu.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_wbu (
    input  wire  rv_pkg::ctrl_t     ctrl,
    input  wire  [rv_pkg::xlen-1:0] pc,
    input  wire  [rv_pkg::xlen-1:0] inst,
    input  wire  [rv_pkg::xlen-1:0] result,
    input  wire  [rv_pkg::xlen-1:0] rdata,
    output logic                    gpr_wen,
    output logic [rv_pkg::xlen-1:0] gpr_wdata,
    output rv_pkg::commit_t         commit
);

    logic [7:0]              load_byte;
    logic [rv_pkg::xlen-1:0] load_data;

    // lbu picks its lane from the address
    assign load_byte = rdata[{result[1:0], 3'b000} +: 8];
    assign load_data = ctrl.byte_access ? {24'b0, load_byte} : rdata;

    assign gpr_wen   = ctrl.gpr_we;
    assign gpr_wdata = ctrl.load ? load_data : result;

    // no-write commits carry rd and wdata as zero
    assign commit.pc     = pc;
    assign commit.inst   = inst;
    assign commit.rd     = ctrl.gpr_we ? ctrl.rd : 4'd0;
    assign commit.wdata  = ctrl.gpr_we ? gpr_wdata : '0;
    assign commit.gpr_we = ctrl.gpr_we;

endmodule

`default_nettype wire

/* verilog/rv_core.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_core #(
    parameter logic [rv_pkg::xlen-1:0] reset_pc   = 32'h8000_0000,
    parameter int                      dmem_words = 64
) (
    input  wire                     clock,
    input  wire                     reset,
    input  wire  [rv_pkg::xlen-1:0] inst,
    output logic [rv_pkg::xlen-1:0] pc,
    output logic                    commit_valid,
    output rv_pkg::commit_t         commit,
    output logic                    store_valid,
    output rv_pkg::store_t          store,
    output logic                    halted,
    output logic                    illegal
);

    rv_pkg::ctrl_t           ctrl;
    rv_pkg::ctrl_t           lsu_ctrl;
    logic [rv_pkg::xlen-1:0] src1;
    logic [rv_pkg::xlen-1:0] src2;
    logic [rv_pkg::xlen-1:0] result;
    logic [rv_pkg::xlen-1:0] dnpc;
    logic [rv_pkg::xlen-1:0] rdata;
    logic [rv_pkg::xlen-1:0] gpr_wdata;
    logic                    wbu_gpr_wen;
    logic                    running;
    logic                    stop;

    assign running = ~reset & ~halted;
    assign stop    = (ctrl.opcode == rv_pkg::op_ebreak) | (ctrl.opcode == rv_pkg::op_illegal);

    // ****************************************
    // pc and halt state
    // ****************************************

    always_ff @(posedge clock) begin
        if (reset) begin
            pc     <= reset_pc;
            halted <= 1'b0;
        end else if (running) begin
            pc     <= dnpc;
            halted <= stop;
        end
    end

    assign illegal      = running & (ctrl.opcode == rv_pkg::op_illegal);
    assign commit_valid = running & (ctrl.opcode != rv_pkg::op_illegal);
    assign store_valid  = running & ctrl.store;

    assign store.addr        = result;
    assign store.data        = ctrl.byte_access ? {24'b0, src2[7:0]} : src2;
    assign store.byte_access = ctrl.byte_access;

    // memory must not change while halted
    always_comb begin
        lsu_ctrl       = ctrl;
        lsu_ctrl.store = ctrl.store & running;
    end

    // ****************************************
    // datapath
    // ****************************************

    rv_idu idu_cpu (
        .inst (inst),
        .ctrl (ctrl)
    );

    rv_gpr gpr_cpu (
        .clock     (clock),
        .reset     (reset),
        .rs1       (ctrl.rs1),
        .rs2       (ctrl.rs2),
        .src1      (src1),
        .src2      (src2),
        .gpr_waddr (commit.rd),
        .gpr_wdata (gpr_wdata),
        .gpr_wen   (wbu_gpr_wen & running)
    );

    rv_exu exu_cpu (
        .ctrl   (ctrl),
        .src1   (src1),
        .src2   (src2),
        .pc     (pc),
        .result (result),
        .dnpc   (dnpc)
    );

    rv_lsu #(
        .dmem_words (dmem_words)
    ) lsu_cpu (
        .clock (clock),
        .reset (reset),
        .ctrl  (lsu_ctrl),
        .addr  (result),
        .wdata (src2),
        .rdata (rdata)
    );

    rv_wbu wbu_cpu (
        .ctrl      (ctrl),
        .pc        (pc),
        .inst      (inst),
        .result    (result),
        .rdata     (rdata),
        .gpr_wen   (wbu_gpr_wen),
        .gpr_wdata (gpr_wdata),
        .commit    (commit)
    );

endmodule

`default_nettype wire

/* bench/rv_core_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_core_tb;

    localparam int          period = 8;
    localparam logic [31:0] nop    = 32'h0000_0013;

    logic                    clock = 1'b0;
    logic                    reset;
    logic [31:0]             inst;
    logic [31:0]             pc;
    logic                    commit_valid;
    rv_pkg::commit_t         commit;
    logic                    store_valid;
    rv_pkg::store_t          store;
    logic                    halted;
    logic                    illegal;

    // program words keyed by {section, address}
    logic [31:0]             prog [logic [63:0]];
    rv_pkg::commit_t         exp_commit[$];
    int                      commit_sec[$];
    rv_pkg::store_t          exp_store[$];
    int                      store_sec[$];
    logic [31:0]             exp_illegal[$];
    int                      illegal_sec[$];

    int sections      = 0;
    int section       = 0;
    int n_commits     = 0;
    int limit_ns      = 0;
    int commit_errors = 0;
    int store_errors  = 0;
    int other_errors  = 0;

    rv_core #(
        .reset_pc   (32'h8000_0000),
        .dmem_words (64)
    ) rv_core_inst (
        .clock        (clock),
        .reset        (reset),
        .inst         (inst),
        .pc           (pc),
        .commit_valid (commit_valid),
        .commit       (commit),
        .store_valid  (store_valid),
        .store        (store),
        .halted       (halted),
        .illegal      (illegal)
    );

    always #(period / 2) clock = ~clock;

    // ****************************************
    // pattern file and instruction memory
    // ****************************************

    task automatic load_patterns();
        int              fd;
        int              n;
        int              c;
        logic [7:0]      kind;
        logic [31:0]     a;
        logic [31:0]     d;
        logic [3:0]      rd;
        logic            flag;
        rv_pkg::commit_t cm;
        rv_pkg::store_t  st;
        fd = $fopen("bench/rv_core_patterns.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("cannot open bench/rv_core_patterns.txt");
        end else begin
            sections = 1;
            n = $fscanf(fd, " %c", kind);
            while (n == 1) begin
                case (kind)
                    "#": begin
                        c = $fgetc(fd);
                        while (c != 10 && c != -1) begin
                            c = $fgetc(fd);
                        end
                    end
                    "R": sections++;
                    "I": begin
                        n = $fscanf(fd, "%h %h", a, d);
                        prog[{32'(sections - 1), a}] = d;
                    end
                    "C": begin
                        n = $fscanf(fd, "%h %h %h %h", a, rd, d, flag);
                        cm        = '0;
                        cm.pc     = a;
                        cm.rd     = rd;
                        cm.wdata  = d;
                        cm.gpr_we = flag;
                        exp_commit.push_back(cm);
                        commit_sec.push_back(sections - 1);
                        n_commits++;
                    end
                    "S": begin
                        n = $fscanf(fd, "%h %h %h", a, d, flag);
                        st.addr        = a;
                        st.data        = d;
                        st.byte_access = flag;
                        exp_store.push_back(st);
                        store_sec.push_back(sections - 1);
                    end
                    "X": begin
                        n = $fscanf(fd, "%h", a);
                        exp_illegal.push_back(a);
                        illegal_sec.push_back(sections - 1);
                    end
                    default: begin
                        other_errors++;
                        $display("unknown record type %c in pattern file", kind);
                    end
                endcase
                n = $fscanf(fd, " %c", kind);
            end
            $fclose(fd);
        end
    endtask

    function automatic logic [31:0] fetch(input int sec, input logic [31:0] addr);
        logic [63:0] key;
        key = {32'(sec), addr};
        if (prog.exists(key)) begin
            return prog[key];
        end else begin
            return nop;
        end
    endfunction

    // ****************************************
    // checks
    // ****************************************

    task automatic check_commit(input rv_pkg::commit_t got);
        rv_pkg::commit_t want;
        if (commit_sec.size() == 0 || commit_sec[0] != section) begin
            commit_errors++;
            $display("unexpected commit at pc %h with no record left to match", got.pc);
        end else begin
            want = exp_commit.pop_front();
            commit_sec.delete(0);
            // the retired word is whatever program memory holds at that pc
            want.inst = fetch(section, want.pc);
            if (got !== want) begin
                commit_errors++;
                $write("FAILED commit got pc=%h inst=%h rd=%h wdata=%h we=%h",
                       got.pc, got.inst, got.rd, got.wdata, got.gpr_we);
                $display(" expected pc=%h inst=%h rd=%h wdata=%h we=%h",
                         want.pc, want.inst, want.rd, want.wdata, want.gpr_we);
            end
        end
    endtask

    task automatic check_store(input rv_pkg::store_t got);
        rv_pkg::store_t want;
        if (store_sec.size() == 0 || store_sec[0] != section) begin
            store_errors++;
            $display("unexpected store to address %h with no record left to match", got.addr);
        end else begin
            want = exp_store.pop_front();
            store_sec.delete(0);
            if (got !== want) begin
                store_errors++;
                $write("FAILED store got addr=%h data=%h byte=%h",
                       got.addr, got.data, got.byte_access);
                $display(" expected addr=%h data=%h byte=%h",
                         want.addr, want.data, want.byte_access);
            end
        end
    endtask

    task automatic check_illegal(input logic [rv_pkg::xlen-1:0] got_pc);
        logic [31:0] want;
        if (illegal_sec.size() == 0 || illegal_sec[0] != section) begin
            other_errors++;
            $display("illegal raised at pc %h where none was expected", got_pc);
        end else begin
            want = exp_illegal.pop_front();
            illegal_sec.delete(0);
            if (got_pc !== want) begin
                other_errors++;
                $display("FAILED illegal pc got %h expected %h", got_pc, want);
            end
        end
    endtask

    task automatic check_drained(input int sec);
        if (commit_sec.size() > 0 && commit_sec[0] == sec) begin
            commit_errors++;
            $display("section %0d halted with commit records left unmatched", sec);
        end
        if (store_sec.size() > 0 && store_sec[0] == sec) begin
            store_errors++;
            $display("section %0d halted with store records left unmatched", sec);
        end
        if (illegal_sec.size() > 0 && illegal_sec[0] == sec) begin
            other_errors++;
            $display("section %0d halted before its illegal instruction", sec);
        end
    endtask

    // ****************************************
    // one program section per reset
    // ****************************************

    task automatic run_section(input int sec);
        logic [31:0] held_pc;
        section = sec;
        @(posedge clock);
        #1;
        reset = 1'b1;
        repeat (8) begin
            @(posedge clock);
            #1;
            inst = fetch(sec, pc);
        end
        reset = 1'b0;
        while (!halted) begin
            @(negedge clock);
            if (commit_valid) check_commit(commit);
            if (store_valid) check_store(store);
            if (illegal) check_illegal(pc);
            // a running cycle either retires or is illegal
            if (commit_valid == illegal) begin
                other_errors++;
                $display("running cycle at pc %h did not give exactly one of commit or illegal",
                         pc);
            end
            @(posedge clock);
            #1;
            inst = fetch(sec, pc);
        end
        held_pc = pc;
        repeat (3) begin
            @(negedge clock);
            if (commit_valid || store_valid || illegal) begin
                other_errors++;
                $display("a strobe is active while the core is halted");
            end
            if (halted !== 1'b1) begin
                other_errors++;
                $display("halted dropped before the next reset");
            end
            if (pc !== held_pc) begin
                other_errors++;
                $display("FAILED pc got %h expected %h while halted", pc, held_pc);
            end
        end
        check_drained(sec);
    endtask

    initial begin
        reset = 1'b1;
        inst  = nop;
        load_patterns();
        limit_ns = (n_commits + 20) * period + sections * 8 * period + period;
        for (int s = 0; s < sections; s++) begin
            run_section(s);
        end
        $display("commit errors %0d, store errors %0d, other errors %0d",
                 commit_errors, store_errors, other_errors);
        if (commit_errors + store_errors + other_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        wait (limit_ns > 0);
        #(limit_ns);
        $display("watchdog expired after %0d ns because the core never halted", limit_ns);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/rv_core_patterns.txt */
# I addr word = program word, C pc rd wdata we = expected commit, S addr data byte = store
# X pc = expected illegal instruction, R = reset and start the next program section
I 80000000 00500093
I 80000004 ffd00113
I 80000008 002081b3
I 8000000c 40208233
I 80000010 123452b7
I 80000014 00001317
I 80000018 00708013
I 8000001c 001003b3
I 80000020 0080046f
I 80000024 00100493
I 80000028 00308463
I 8000002c 00309463
I 80000030 00200493
I 80000034 04000513
I 80000038 00552223
I 8000003c 00452583
I 80000040 002504a3
I 80000044 00954603
I 80000048 03140713
I 8000004c 000706e7
I 80000050 00300493
I 80000054 00558463
I 80000058 00400493
I 8000005c 00709463
I 80000060 00100073
C 80000000 1 00000005 1
C 80000004 2 fffffffd 1
C 80000008 3 00000002 1
C 8000000c 4 00000008 1
C 80000010 5 12345000 1
C 80000014 6 80001014 1
C 80000018 0 0000000c 1
C 8000001c 7 00000005 1
C 80000020 8 80000024 1
C 80000028 0 00000000 0
C 8000002c 0 00000000 0
C 80000034 a 00000040 1
C 80000038 0 00000000 0
C 8000003c b 12345000 1
C 80000040 0 00000000 0
C 80000044 c 000000fd 1
C 80000048 e 80000055 1
C 8000004c d 80000050 1
C 80000054 0 00000000 0
C 8000005c 0 00000000 0
C 80000060 0 00000000 0
S 00000044 12345000 0
S 00000049 000000fd 1
# registers read zero again, then an add with rd above x15
R
I 80000000 00108133
I 80000004 00108833
C 80000000 2 00000000 1
X 80000004

/* src.f */
verilog/rv_pkg.sv
verilog/rv_idu.sv
verilog/rv_gpr.sv
verilog/rv_exu.sv
verilog/rv_lsu.sv
verilog/rv_wbu.sv
verilog/rv_core.sv
bench/rv_core_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = rv_core_tb
FILELIST  = src.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -x "TEST PASS" > /dev/null

clean:
	rm -rf obj_dir
